//--- source/frontend_pkg.sv
package frontend_pkg;

    // Address layout
    localparam int PC_WIDTH = 32;
    localparam int INST_OFFSET_BITS = 2;
    localparam int LINE_OFFSET_BITS = 5;

    // Instruction slots in one 32-byte line, counted minus one
    localparam int LEN_BITS = LINE_OFFSET_BITS - INST_OFFSET_BITS;

    // A block not aligned to this many offset bits spans two fetch halves
    localparam int FETCH_ALIGN_BITS = 3;

    // Queue index width for the default depth of 8
    localparam int FTQ_ID_BITS = 3;

    typedef logic [PC_WIDTH-1:0] pc_t;

    typedef logic [FTQ_ID_BITS-1:0] ftq_id_t;

    // One fetch block, from the predictor through the queue to the IFU
    typedef struct packed {
        logic                valid;
        pc_t                 start_pc;
        logic [LEN_BITS-1:0] length;
        logic                is_cross_cacheline;
    } fetch_block_t;

    // Backend view of the oldest committing block
    typedef struct packed {
        logic is_branch;
        logic is_conditional;
        logic is_taken;
    } commit_meta_t;

endpackage

//--- source/bpu_pkg.sv
package bpu_pkg;

    // Saturating counter width
    localparam int CTR_BITS = 2;

    // Reset value, weakly not-taken
    localparam logic [CTR_BITS-1:0] CTR_WEAK_NT = 2'b01;

    // Stored next to each block in the queue
    typedef struct packed {
        logic [CTR_BITS-1:0] provider_ctr_bits;
        logic                predicted_taken;
    } pred_meta_t;

    // Training record sent back from the queue after a branch commit
    typedef struct packed {
        logic                valid;
        frontend_pkg::pc_t   start_pc;
        logic                is_cross_cacheline;
        logic                is_branch;
        logic                is_conditional;
        logic                is_taken;
        logic                predicted_taken;
        logic [CTR_BITS-1:0] provider_ctr_bits;
    } train_t;

endpackage

//--- source/ftq_entry_ram.sv
`timescale 1ns/1ps

module ftq_entry_ram #(
    parameter int  DEPTH     = 8,
    parameter type payload_t = logic
) (
    input  logic                     clk,

    // Write port, driven by the predict pointer
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  payload_t                 wdata_i,

    // IFU side read
    input  logic [$clog2(DEPTH)-1:0] raddr_a_i,
    output payload_t                 rdata_a_o,

    // Commit side read
    input  logic [$clog2(DEPTH)-1:0] raddr_b_i,
    output payload_t                 rdata_b_o
);

    payload_t mem_q [DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // Both reads are combinational
    assign rdata_a_o = mem_q[raddr_a_i];
    assign rdata_b_o = mem_q[raddr_b_i];

endmodule

//--- source/next_line_predictor.sv
`timescale 1ns/1ps

module next_line_predictor #(
    parameter int                CTR_ENTRIES = 16,
    parameter frontend_pkg::pc_t RESET_PC    = 32'h8000_0000
) (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       full_i,
    input  logic                       flush_i,
    input  frontend_pkg::pc_t          redirect_pc_i,
    input  bpu_pkg::train_t            train_i,

    output frontend_pkg::fetch_block_t block_o,
    output bpu_pkg::pred_meta_t        meta_o
);

    localparam int IDX_BITS = $clog2(CTR_ENTRIES);
    localparam int IDX_LSB = frontend_pkg::INST_OFFSET_BITS;

    frontend_pkg::pc_t pc_q;
    frontend_pkg::pc_t next_line_pc;

    logic [frontend_pkg::LEN_BITS-1:0] line_slot;
    logic [IDX_BITS-1:0]               pred_idx;
    logic [IDX_BITS-1:0]               train_idx;

    logic [bpu_pkg::CTR_BITS-1:0] ctr_q [CTR_ENTRIES];

    // Slot of the current pc inside its cache line
    assign line_slot = pc_q[frontend_pkg::LINE_OFFSET_BITS-1:IDX_LSB];

    // Always sequential, first byte of the following line
    assign next_line_pc = {pc_q[frontend_pkg::PC_WIDTH-1:frontend_pkg::LINE_OFFSET_BITS] + 1'b1,
                           {frontend_pkg::LINE_OFFSET_BITS{1'b0}}};

    // Block runs from pc to the end of the line
    assign block_o.valid              = !full_i && !flush_i;
    assign block_o.start_pc           = pc_q;
    assign block_o.length             = ~line_slot;
    assign block_o.is_cross_cacheline = |pc_q[frontend_pkg::FETCH_ALIGN_BITS-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (flush_i) begin
            pc_q <= redirect_pc_i;
        end else if (block_o.valid) begin
            pc_q <= next_line_pc;
        end
    end

    assign pred_idx  = pc_q[IDX_BITS+IDX_LSB-1:IDX_LSB];
    assign train_idx = train_i.start_pc[IDX_BITS+IDX_LSB-1:IDX_LSB];

    // Counter msb gives the taken guess
    assign meta_o.provider_ctr_bits = ctr_q[pred_idx];
    assign meta_o.predicted_taken   = ctr_q[pred_idx][bpu_pkg::CTR_BITS-1];

    // Saturating update on conditional branch outcomes
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < CTR_ENTRIES; i++) begin
                ctr_q[i] <= bpu_pkg::CTR_WEAK_NT;
            end
        end else if (train_i.valid && train_i.is_conditional) begin
            if (train_i.is_taken && ctr_q[train_idx] != '1) begin
                ctr_q[train_idx] <= ctr_q[train_idx] + 1'b1;
            end else if (!train_i.is_taken && ctr_q[train_idx] != '0) begin
                ctr_q[train_idx] <= ctr_q[train_idx] - 1'b1;
            end
        end
    end

endmodule

//--- source/ftq.sv
`timescale 1ns/1ps

module ftq #(
    parameter int FTQ_SIZE     = 8,
    parameter int COMMIT_WIDTH = 2
) (
    input  logic                          clk,
    input  logic                          rst,

    // Predictor side
    input  frontend_pkg::fetch_block_t    block_i,
    input  bpu_pkg::pred_meta_t           meta_i,
    output logic                          full_o,

    // IFU side, accept comes back in the same cycle
    output frontend_pkg::fetch_block_t    ifu_block_o,
    output logic [$clog2(FTQ_SIZE)-1:0]   ifu_ftq_id_o,
    input  logic                          ifu_accept_i,

    // Backend commit
    input  logic [COMMIT_WIDTH-1:0]       commit_mask_i,
    input  logic [$clog2(FTQ_SIZE)-1:0]   commit_ftq_id_i,
    input  frontend_pkg::commit_meta_t    commit_meta_i,

    // Backend flush
    input  logic                          flush_i,
    input  logic [$clog2(FTQ_SIZE)-1:0]   flush_ftq_id_i,

    output bpu_pkg::train_t               train_o
);

    localparam int IDX_W = $clog2(FTQ_SIZE);

    typedef logic [IDX_W-1:0] idx_t;

    idx_t pred_ptr_q;
    idx_t ifu_ptr_q;
    idx_t commit_ptr_q;
    idx_t flush_span;

    logic [FTQ_SIZE-1:0] valid_q;
    logic [FTQ_SIZE-1:0] valid_d;

    logic [$clog2(COMMIT_WIDTH):0] commit_num;

    frontend_pkg::fetch_block_t ifu_rd_block;
    frontend_pkg::fetch_block_t cmt_rd_block;
    bpu_pkg::pred_meta_t        cmt_rd_meta;

    ftq_entry_ram #(
        .DEPTH     (FTQ_SIZE),
        .payload_t (frontend_pkg::fetch_block_t)
    ) u_block_ram (
        .clk       (clk),
        .we_i      (block_i.valid),
        .waddr_i   (pred_ptr_q),
        .wdata_i   (block_i),
        .raddr_a_i (ifu_ptr_q),
        .rdata_a_o (ifu_rd_block),
        .raddr_b_i (commit_ftq_id_i),
        .rdata_b_o (cmt_rd_block)
    );

    // Meta is only needed on the commit side
    ftq_entry_ram #(
        .DEPTH     (FTQ_SIZE),
        .payload_t (bpu_pkg::pred_meta_t)
    ) u_meta_ram (
        .clk       (clk),
        .we_i      (block_i.valid),
        .waddr_i   (pred_ptr_q),
        .wdata_i   (meta_i),
        .raddr_a_i ('0),
        .rdata_a_o (),
        .raddr_b_i (commit_ftq_id_i),
        .rdata_b_o (cmt_rd_meta)
    );

    always_comb begin
        commit_num = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            commit_num = commit_num + commit_mask_i[i];
        end
    end

    // One slot stays empty so full and empty differ
    assign full_o = (idx_t'(pred_ptr_q + 1'b1) == commit_ptr_q);

    assign flush_span = flush_ftq_id_i - commit_ptr_q;

    always_comb begin
        idx_t slot;
        valid_d = valid_q;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            slot = commit_ptr_q + idx_t'(i);
            if (i < commit_num) begin
                valid_d[slot] = 1'b0;
            end
        end
        if (block_i.valid) begin
            valid_d[pred_ptr_q] = 1'b1;
        end
        // Keep only commit pointer through the flushed block
        if (flush_i) begin
            for (int i = 0; i < FTQ_SIZE; i++) begin
                slot = idx_t'(i) - commit_ptr_q;
                if (slot > flush_span) begin
                    valid_d[i] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q      <= '0;
            pred_ptr_q   <= '0;
            ifu_ptr_q    <= '0;
            commit_ptr_q <= '0;
        end else begin
            valid_q      <= valid_d;
            commit_ptr_q <= commit_ptr_q + idx_t'(commit_num);
            if (flush_i) begin
                // Restart just after the flushed block
                pred_ptr_q <= flush_ftq_id_i + 1'b1;
                ifu_ptr_q  <= flush_ftq_id_i + 1'b1;
            end else begin
                if (block_i.valid) begin
                    pred_ptr_q <= pred_ptr_q + 1'b1;
                end
                if (ifu_accept_i) begin
                    ifu_ptr_q <= ifu_ptr_q + 1'b1;
                end
            end
        end
    end

    // Slot valid comes from the queue state, not the stored copy
    always_comb begin
        ifu_block_o       = ifu_rd_block;
        ifu_block_o.valid = valid_q[ifu_ptr_q];
    end

    assign ifu_ftq_id_o = ifu_ptr_q;

    // Training record, one cycle after a branch block commits
    always_ff @(posedge clk) begin
        if (rst) begin
            train_o <= '0;
        end else begin
            train_o <= '0;
            if (commit_mask_i[0] && commit_meta_i.is_branch) begin
                train_o.valid              <= 1'b1;
                train_o.start_pc           <= cmt_rd_block.start_pc;
                train_o.is_cross_cacheline <= cmt_rd_block.is_cross_cacheline;
                train_o.is_branch          <= commit_meta_i.is_branch;
                train_o.is_conditional     <= commit_meta_i.is_conditional;
                train_o.is_taken           <= commit_meta_i.is_taken;
                train_o.predicted_taken    <= cmt_rd_meta.predicted_taken;
                train_o.provider_ctr_bits  <= cmt_rd_meta.provider_ctr_bits;
            end
        end
    end

    // IFU may only take a block the queue holds
    a_accept_valid: assert property (@(posedge clk) disable iff (rst)
        ifu_accept_i |-> ifu_block_o.valid);

    for (genvar g = 0; g < COMMIT_WIDTH; g++) begin : g_commit_chk
        a_commit_valid: assert property (@(posedge clk) disable iff (rst)
            commit_mask_i[g] |-> valid_q[commit_ptr_q + idx_t'(g)]);
    end

endmodule

//--- source/frontend_top.sv
`timescale 1ns/1ps

module frontend_top #(
    parameter int                FTQ_SIZE     = 8,
    parameter int                COMMIT_WIDTH = 2,
    parameter int                CTR_ENTRIES  = 16,
    parameter frontend_pkg::pc_t RESET_PC     = 32'h8000_0000
) (
    input  logic                        clk,
    input  logic                        rst,

    // Backend
    input  frontend_pkg::pc_t           redirect_pc_i,
    input  logic                        flush_i,
    input  logic [$clog2(FTQ_SIZE)-1:0] flush_ftq_id_i,
    input  logic [COMMIT_WIDTH-1:0]     commit_mask_i,
    input  logic [$clog2(FTQ_SIZE)-1:0] commit_ftq_id_i,
    input  frontend_pkg::commit_meta_t  commit_meta_i,

    // IFU
    input  logic                        ifu_accept_i,
    output frontend_pkg::fetch_block_t  ifu_block_o,
    output logic [$clog2(FTQ_SIZE)-1:0] ifu_ftq_id_o,

    // Status
    output logic                        full_o,
    output bpu_pkg::train_t             train_o
);

    frontend_pkg::fetch_block_t pred_block;
    bpu_pkg::pred_meta_t        pred_meta;

    next_line_predictor #(
        .CTR_ENTRIES   (CTR_ENTRIES),
        .RESET_PC      (RESET_PC)
    ) u_predictor (
        .clk           (clk),
        .rst           (rst),
        .full_i        (full_o),
        .flush_i       (flush_i),
        .redirect_pc_i (redirect_pc_i),
        .train_i       (train_o),
        .block_o       (pred_block),
        .meta_o        (pred_meta)
    );

    ftq #(
        .FTQ_SIZE        (FTQ_SIZE),
        .COMMIT_WIDTH    (COMMIT_WIDTH)
    ) u_ftq (
        .clk             (clk),
        .rst             (rst),
        .block_i         (pred_block),
        .meta_i          (pred_meta),
        .full_o          (full_o),
        .ifu_block_o     (ifu_block_o),
        .ifu_ftq_id_o    (ifu_ftq_id_o),
        .ifu_accept_i    (ifu_accept_i),
        .commit_mask_i   (commit_mask_i),
        .commit_ftq_id_i (commit_ftq_id_i),
        .commit_meta_i   (commit_meta_i),
        .flush_i         (flush_i),
        .flush_ftq_id_i  (flush_ftq_id_i),
        .train_o         (train_o)
    );

endmodule

//--- tb/frontend_ref.svh
`ifndef FRONTEND_REF_SVH
`define FRONTEND_REF_SVH

// Block from pc to the end of its 32-byte line, eight slots per line
function automatic frontend_pkg::fetch_block_t ref_block(input frontend_pkg::pc_t pc);
    frontend_pkg::fetch_block_t blk;
    blk.valid              = 1'b1;
    blk.start_pc           = pc;
    blk.length             = 3'd7 - pc[4:2];
    blk.is_cross_cacheline = (pc[2:0] != 3'b000);
    return blk;
endfunction

// Next prediction starts at the following line boundary
function automatic frontend_pkg::pc_t ref_next_pc(input frontend_pkg::pc_t pc);
    return {pc[31:5] + 27'd1, 5'b00000};
endfunction

function automatic logic [3:0] ref_ctr_index(input frontend_pkg::pc_t pc);
    return pc[5:2];
endfunction

// Two-bit saturating counter step
function automatic logic [1:0] ref_ctr_update(input logic [1:0] ctr, input logic taken);
    if (taken) begin
        return (ctr == 2'b11) ? ctr : ctr + 2'b01;
    end
    return (ctr == 2'b00) ? ctr : ctr - 2'b01;
endfunction

// Record expected one cycle after a branch block commits
function automatic bpu_pkg::train_t ref_train(input frontend_pkg::fetch_block_t blk,
                                              input logic [1:0] ctr,
                                              input frontend_pkg::commit_meta_t meta);
    bpu_pkg::train_t rec;
    rec.valid              = 1'b1;
    rec.start_pc           = blk.start_pc;
    rec.is_cross_cacheline = blk.is_cross_cacheline;
    rec.is_branch          = meta.is_branch;
    rec.is_conditional     = meta.is_conditional;
    rec.is_taken           = meta.is_taken;
    rec.predicted_taken    = ctr[1];
    rec.provider_ctr_bits  = ctr;
    return rec;
endfunction

`endif

//--- tb/frontend_tb.sv
`timescale 1ns/1ps

module frontend_tb;

    localparam int FTQ_SIZE = 8;
    localparam int COMMIT_WIDTH = 2;
    localparam int CTR_ENTRIES = 16;
    localparam frontend_pkg::pc_t RESET_PC = 32'h8000_0000;
    localparam int TIMEOUT = 300;

    typedef logic [$clog2(FTQ_SIZE)-1:0] id_t;

    logic                       clk;
    logic                       rst;
    frontend_pkg::pc_t          redirect_pc;
    logic                       flush;
    id_t                        flush_id;
    logic [COMMIT_WIDTH-1:0]    commit_mask;
    id_t                        commit_id;
    frontend_pkg::commit_meta_t commit_meta;
    logic                       ifu_accept;
    frontend_pkg::fetch_block_t ifu_block;
    id_t                        ifu_id;
    logic                       full;
    bpu_pkg::train_t            train;

    `include "frontend_ref.svh"

    // Stimulus controls
    logic              accept_en;
    logic              commit_en;
    logic              flush_req;
    int                meta_mode;
    frontend_pkg::pc_t flush_pc_req;
    int                seed;

    // Shadow queue and counter table
    id_t                        pred_ptr;
    id_t                        ifu_ptr;
    id_t                        commit_ptr;
    frontend_pkg::pc_t          model_pc;
    frontend_pkg::fetch_block_t exp_blk [FTQ_SIZE];
    logic [1:0]                 exp_ctr [FTQ_SIZE];
    logic [1:0]                 shadow_ctr [CTR_ENTRIES];
    bpu_pkg::train_t            exp_train;

    int                n_checks;
    int                n_errors;
    int                n_accepts;
    int                n_commits;
    int                n_trains;
    int                n_flush_checks;
    int                test_err_base;
    string             test_name;
    logic              post_flush;
    id_t               flush_chk_id;
    frontend_pkg::pc_t flush_chk_pc;
    logic [1:0]        last_train_ctr;
    logic              timed_out;

    frontend_top #(
        .FTQ_SIZE        (FTQ_SIZE),
        .COMMIT_WIDTH    (COMMIT_WIDTH),
        .CTR_ENTRIES     (CTR_ENTRIES),
        .RESET_PC        (RESET_PC)
    ) u_dut (
        .clk             (clk),
        .rst             (rst),
        .redirect_pc_i   (redirect_pc),
        .flush_i         (flush),
        .flush_ftq_id_i  (flush_id),
        .commit_mask_i   (commit_mask),
        .commit_ftq_id_i (commit_id),
        .commit_meta_i   (commit_meta),
        .ifu_accept_i    (ifu_accept),
        .ifu_block_o     (ifu_block),
        .ifu_ftq_id_o    (ifu_id),
        .full_o          (full),
        .train_o         (train)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string what, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        n_checks++;
        assert (exp_v === act_v) else begin
            n_errors++;
            $display("MISMATCH %s %s: expected %h actual %h", test_name, what, exp_v, act_v);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("TIMEOUT in %s: %s", test_name, what);
        timed_out = 1'b1;
    endtask

    task automatic end_test();
        $display("%s finished with %0d errors", test_name, n_errors - test_err_base);
        test_err_base = n_errors;
    endtask

    // IFU and backend models, driven 1 ns after the edge
    always @(posedge clk) begin
        id_t         avail;
        int          r;
        logic [31:0] rnd;
        #1;
        avail = ifu_ptr - commit_ptr;
        rnd = $random(seed);
        flush = 1'b0;
        ifu_accept = 1'b0;
        commit_mask = '0;
        commit_meta = '0;
        if (!rst && flush_req && avail != 0) begin
            r = $unsigned($random(seed)) % int'(avail);
            flush = 1'b1;
            flush_id = commit_ptr + id_t'(r);
            redirect_pc = flush_pc_req;
            flush_req = 1'b0;
        end else if (!rst) begin
            ifu_accept = accept_en && ifu_block.valid && (rnd[1:0] != 2'b00);
            if (commit_en && avail != 0) begin
                if (rnd[3:2] == 2'b11 && avail > 1) begin
                    commit_mask = 2'b11;
                end else if (rnd[3:2] != 2'b00) begin
                    commit_mask = 2'b01;
                end
                commit_id = commit_ptr;
                if (meta_mode == 1) begin
                    commit_meta = {rnd[6], rnd[5], rnd[4]};
                end else if (meta_mode == 2) begin
                    commit_meta = 3'b111;
                end
            end
        end
    end

    // Compare at the falling edge, where inputs and outputs are settled
    always @(negedge clk) begin
        bpu_pkg::train_t next_train;
        logic            exp_full;
        int              n_cmt;
        if (!rst) begin
            exp_full = (id_t'(pred_ptr + 1'b1) == commit_ptr);
            check_value("full", 64'(exp_full), 64'(full));
            // Predictor writes one block per cycle unless held
            if (!exp_full && !flush) begin
                exp_blk[pred_ptr] = ref_block(model_pc);
                exp_ctr[pred_ptr] = shadow_ctr[ref_ctr_index(model_pc)];
                pred_ptr = pred_ptr + 1'b1;
                model_pc = ref_next_pc(model_pc);
            end
            check_value("train", 64'(exp_train), 64'(train));
            if (exp_train.valid) begin
                n_trains++;
                last_train_ctr = train.provider_ctr_bits;
                if (exp_train.is_conditional) begin
                    shadow_ctr[ref_ctr_index(exp_train.start_pc)] = ref_ctr_update(
                        shadow_ctr[ref_ctr_index(exp_train.start_pc)], exp_train.is_taken);
                end
            end
            if (ifu_accept) begin
                check_value("ifu id", 64'(ifu_ptr), 64'(ifu_id));
                check_value("ifu block", 64'(exp_blk[ifu_ptr]), 64'(ifu_block));
                if (post_flush) begin
                    check_value("flush id", 64'(flush_chk_id), 64'(ifu_id));
                    check_value("flush pc", 64'(flush_chk_pc), 64'(ifu_block.start_pc));
                    post_flush = 1'b0;
                    n_flush_checks++;
                end
                ifu_ptr = ifu_ptr + 1'b1;
                n_accepts++;
            end
            next_train = '0;
            if (commit_mask[0] && commit_meta.is_branch) begin
                next_train = ref_train(exp_blk[commit_ptr], exp_ctr[commit_ptr], commit_meta);
            end
            n_cmt = 0;
            for (int i = 0; i < COMMIT_WIDTH; i++) begin
                n_cmt = n_cmt + int'(commit_mask[i]);
            end
            commit_ptr = commit_ptr + id_t'(n_cmt);
            n_commits = n_commits + n_cmt;
            exp_train = next_train;
            if (flush) begin
                pred_ptr = flush_id + 1'b1;
                ifu_ptr = flush_id + 1'b1;
                model_pc = redirect_pc;
                post_flush = 1'b1;
                flush_chk_id = flush_id + 1'b1;
                flush_chk_pc = redirect_pc;
            end
        end
    end

    // The five tests in order, left early when a wait runs out
    task automatic run_tests();
        int t;
        int base;

        test_name = "sequential";
        accept_en = 1'b1;
        for (t = 0; t < TIMEOUT && n_accepts < 5; t++) @(posedge clk);
        if (n_accepts < 5) begin
            report_timeout("IFU received too few blocks");
            return;
        end
        end_test();

        test_name = "backpressure";
        accept_en = 1'b0;
        for (t = 0; t < TIMEOUT && !full; t++) @(posedge clk);
        if (!full) begin
            report_timeout("queue never became full");
            return;
        end
        check_value("queued", 64'(FTQ_SIZE - 1), 64'(id_t'(pred_ptr - commit_ptr)));
        accept_en = 1'b1;
        for (t = 0; t < TIMEOUT && ifu_ptr != pred_ptr; t++) @(posedge clk);
        if (ifu_ptr != pred_ptr) begin
            report_timeout("IFU did not drain the queue");
            return;
        end
        end_test();

        test_name = "commit";
        commit_en = 1'b1;
        meta_mode = 1;
        for (t = 0; t < TIMEOUT && full; t++) @(posedge clk);
        if (full) begin
            report_timeout("full stayed high while committing");
            return;
        end
        base = n_commits;
        for (t = 0; t < TIMEOUT && n_commits < base + 24; t++) @(posedge clk);
        if (n_commits < base + 24) begin
            report_timeout("too few blocks committed");
            return;
        end
        end_test();

        test_name = "flush";
        for (int k = 0; k < 2; k++) begin
            flush_pc_req = (k == 0) ? 32'h8000_1234 : 32'h8000_2008;
            base = n_flush_checks;
            flush_req = 1'b1;
            for (t = 0; t < TIMEOUT && n_flush_checks == base; t++) @(posedge clk);
            if (n_flush_checks == base) begin
                report_timeout("no IFU block after the flush");
                return;
            end
            base = n_accepts;
            for (t = 0; t < TIMEOUT && n_accepts < base + 6; t++) @(posedge clk);
            if (n_accepts < base + 6) begin
                report_timeout("fetch stalled after the flush");
                return;
            end
        end
        end_test();

        test_name = "training";
        meta_mode = 2;
        base = n_trains;
        for (t = 0; t < TIMEOUT && n_trains < base + 20; t++) @(posedge clk);
        if (n_trains < base + 20) begin
            report_timeout("too few training pulses");
            return;
        end
        check_value("saturated counter", 64'(2'b11), 64'(last_train_ctr));
        end_test();
    endtask

    initial begin
        seed = 32'hca12_debc;
        clk = 1'b0;
        rst = 1'b1;
        redirect_pc = '0;
        flush = 1'b0;
        flush_id = '0;
        commit_mask = '0;
        commit_id = '0;
        commit_meta = '0;
        ifu_accept = 1'b0;
        accept_en = 1'b0;
        commit_en = 1'b0;
        flush_req = 1'b0;
        meta_mode = 0;
        flush_pc_req = '0;
        pred_ptr = '0;
        ifu_ptr = '0;
        commit_ptr = '0;
        model_pc = RESET_PC;
        for (int i = 0; i < CTR_ENTRIES; i++) begin
            shadow_ctr[i] = 2'b01;
        end
        exp_train = '0;
        n_checks = 0;
        n_errors = 0;
        n_accepts = 0;
        n_commits = 0;
        n_trains = 0;
        n_flush_checks = 0;
        test_err_base = 0;
        post_flush = 1'b0;
        last_train_ctr = '0;
        timed_out = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;

        run_tests();

        accept_en = 1'b0;
        commit_en = 1'b0;
        $display("checks=%0d errors=%0d", n_checks, n_errors);
        if (n_errors == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+tb
source/frontend_pkg.sv
source/bpu_pkg.sv
source/ftq_entry_ram.sv
source/next_line_predictor.sv
source/ftq.sv
source/frontend_top.sv
tb/frontend_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module frontend_tb -f vlog.f \
    -o frontend_sim > sim.log 2>&1 \
    && ./obj_dir/frontend_sim >> sim.log 2>&1 \
    || echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && echo "Simulation FAILED" && exit 1
echo "Simulation PASSED"
exit 0
